// ==== hw/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // byte address and data word as seen by the cpu
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // word address, byte offset stripped
    typedef logic [29:0] line_addr_t;

    // one enable per byte lane, all zero means load
    typedef logic [3:0] byte_en_t;

    typedef struct packed {
        addr_t    addr;
        byte_en_t wen;
        data_t    wdata;
    } cpu_req_t;

    // miss job handed from the core to the axi port
    typedef struct packed {
        logic       wb;      // victim needs write-back
        line_addr_t rd_addr; // word to refill
        line_addr_t wb_addr; // victim word
        data_t      wb_data;
    } mem_job_t;

endpackage

`default_nettype wire

// ==== hw/cache_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ram import dcache_pkg::*; #(
    parameter int  DEPTH_W   = 10,
    parameter type payload_t = data_t
) (
    input  wire logic               clk,
    input  wire logic               we,
    input  wire logic [DEPTH_W-1:0] waddr,
    input  wire payload_t           wdata,
    input  wire byte_en_t           wbe,
    input  wire logic               re,
    input  wire logic [DEPTH_W-1:0] raddr,
    output payload_t                rdata
);
    localparam int W = $bits(payload_t);

    logic [W-1:0] mem [0:(1 << DEPTH_W)-1];
    logic [W-1:0] wdata_bits;

    assign wdata_bits = wdata;

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < W; i++) begin
                if (wbe[i / 8]) mem[waddr][i] <= wdata_bits[i]; // lane i/8
            end
        end
        if (re) rdata <= payload_t'(mem[raddr]); // holds when re is low
    end

endmodule

`default_nettype wire

// ==== hw/dcache_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_core import dcache_pkg::*; #(
    parameter int INDEX_W = 10
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     req,
    input  wire cpu_req_t creq,
    output data_t         rdata,
    output logic          done,
    output logic          mem_start,
    output mem_job_t      mem_job,
    input  wire logic     mem_finish,
    input  wire data_t    refill_data
);
    localparam int SETS = 1 << INDEX_W;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        FILL
    } state_t;

    state_t state;

    logic [INDEX_W-1:0] index;
    line_addr_t         line;
    logic               store;

    line_addr_t tag_q [2];
    data_t      data_q [2];

    logic [SETS-1:0][1:0] valid_q;
    logic [SETS-1:0][1:0] dirty_q;
    logic [SETS-1:0]      lru_q;   // way to replace next

    logic [1:0] way_hit;
    logic       hit;
    logic       hit_way;
    logic       victim;
    logic       used_way;
    logic       rd_en;

    data_t    old_word;
    data_t    new_word;
    data_t    refill_q;
    logic [1:0] tag_we;
    logic [1:0] data_we;
    byte_en_t data_wbe;
    data_t    data_wdata;

    function automatic data_t merge_bytes(data_t old, byte_en_t be, data_t wd);
        data_t res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[b*8 +: 8] = wd[b*8 +: 8];
        end
        return res;
    endfunction

    assign line  = creq.addr[31:2];
    assign index = creq.addr[INDEX_W+1:2];
    assign store = |creq.wen;
    assign rd_en = (state == IDLE) && req;

    // tag compare on the registered array outputs
    assign way_hit[0] = valid_q[index][0] && (tag_q[0] == line);
    assign way_hit[1] = valid_q[index][1] && (tag_q[1] == line);
    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];
    assign victim     = lru_q[index];
    assign used_way   = (state == FILL) ? victim : hit_way;

    // loads see the old word, stores see it with their bytes merged in
    assign old_word = (state == FILL) ? refill_q : data_q[hit_way];
    assign new_word = merge_bytes(old_word, creq.wen, creq.wdata);
    assign rdata    = new_word;
    assign done     = ((state == LOOKUP) && hit) || (state == FILL);

    assign data_wbe   = (state == FILL) ? 4'hf : creq.wen;
    assign data_wdata = (state == FILL) ? new_word : creq.wdata;

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign tag_we[w]  = (state == FILL) && (victim == 1'(w));
        assign data_we[w] = tag_we[w] ||
                            ((state == LOOKUP) && hit && store && (hit_way == 1'(w)));

        cache_ram #(
            .DEPTH_W   (INDEX_W),
            .payload_t (line_addr_t)
        ) tag_ram (
            .clk   (clk),
            .we    (tag_we[w]),
            .waddr (index),
            .wdata (line),
            .wbe   ('1),
            .re    (rd_en),
            .raddr (index),
            .rdata (tag_q[w])
        );

        cache_ram #(
            .DEPTH_W   (INDEX_W),
            .payload_t (data_t)
        ) data_ram (
            .clk   (clk),
            .we    (data_we[w]),
            .waddr (index),
            .wdata (data_wdata),
            .wbe   (data_wbe),
            .re    (rd_en),
            .raddr (index),
            .rdata (data_q[w])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            mem_start <= 1'b0;
            valid_q   <= '0;
            dirty_q   <= '0;
            lru_q     <= '0;
        end else begin
            mem_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) state <= LOOKUP;
                end
                LOOKUP: begin
                    if (hit) begin
                        state <= IDLE;
                        if (store) dirty_q[index][hit_way] <= 1'b1;
                    end else begin
                        state     <= MISS;
                        mem_start <= 1'b1; // first MISS cycle
                    end
                end
                MISS: begin
                    if (mem_finish) state <= FILL;
                end
                FILL: begin
                    state                   <= IDLE;
                    valid_q[index][victim] <= 1'b1;
                    dirty_q[index][victim] <= store;
                end
                default: state <= IDLE;
            endcase
            if (done) lru_q[index] <= ~used_way; // point at the other way
        end
    end

    // miss job and refill word
    always_ff @(posedge clk) begin
        if ((state == LOOKUP) && !hit) begin
            mem_job.wb      <= valid_q[index][victim] && dirty_q[index][victim];
            mem_job.rd_addr <= line;
            mem_job.wb_addr <= tag_q[victim];
            mem_job.wb_data <= data_q[victim];
        end
        if (mem_finish) refill_q <= refill_data;
    end

endmodule

`default_nettype wire

// ==== hw/axi_refill_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_refill_port import dcache_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     mem_start,
    input  wire mem_job_t mem_job,
    output logic          mem_finish,
    output data_t         refill_data,
    output addr_t         araddr,
    output logic          arvalid,
    input  wire logic     arready,
    input  wire data_t    rdata_m,
    input  wire logic     rvalid,
    output logic          rready,
    output addr_t         awaddr,
    output logic          awvalid,
    output data_t         wdata,
    output logic          wvalid,
    input  wire logic     awready,
    input  wire logic     wready,
    input  wire logic     bvalid,
    output logic          bready
);
    logic rd_req;  // read transaction open
    logic wr_req;  // write-back open
    logic ar_done;
    logic r_done;
    logic aw_done;
    logic w_done;
    logic b_done;

    // job stays stable in the core for the whole miss
    assign araddr = {mem_job.rd_addr, 2'b00};
    assign awaddr = {mem_job.wb_addr, 2'b00};
    assign wdata  = mem_job.wb_data;

    assign arvalid = rd_req && !ar_done;
    assign rready  = rd_req && ar_done && !r_done;
    assign awvalid = wr_req && !aw_done;
    assign wvalid  = wr_req && !w_done;
    assign bready  = wr_req && aw_done && w_done && !b_done;

    assign mem_finish = rd_req && r_done && (!wr_req || b_done);

    always_ff @(posedge clk) begin
        if (rst || mem_finish) begin
            rd_req  <= 1'b0;
            wr_req  <= 1'b0;
            ar_done <= 1'b0;
            r_done  <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            b_done  <= 1'b0;
        end else begin
            if (mem_start) begin
                rd_req <= 1'b1;
                wr_req <= mem_job.wb;
            end
            if (arvalid && arready) ar_done <= 1'b1;
            if (rvalid && rready) r_done <= 1'b1;
            if (awvalid && awready) aw_done <= 1'b1;
            if (wvalid && wready) w_done <= 1'b1;
            if (bvalid && bready) b_done <= 1'b1;
        end
    end

    // held until the next read beat
    always_ff @(posedge clk) begin
        if (rvalid && rready) refill_data <= rdata_m;
    end

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int INDEX_W = 10
) (
    input  wire logic     clk,
    input  wire logic     rst,
    // cpu side
    input  wire logic     req,
    input  wire cpu_req_t creq,
    output data_t         rdata,
    output logic          done,
    // axi side
    output addr_t         araddr,
    output logic          arvalid,
    input  wire logic     arready,
    input  wire data_t    rdata_m,
    input  wire logic     rvalid,
    output logic          rready,
    output addr_t         awaddr,
    output logic          awvalid,
    input  wire logic     awready,
    output data_t         wdata,
    output logic          wvalid,
    input  wire logic     wready,
    input  wire logic     bvalid,
    output logic          bready
);
    logic     mem_start;
    mem_job_t mem_job;
    logic     mem_finish;
    data_t    refill_data;

    dcache_core #(
        .INDEX_W (INDEX_W)
    ) core (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .creq        (creq),
        .rdata       (rdata),
        .done        (done),
        .mem_start   (mem_start),
        .mem_job     (mem_job),
        .mem_finish  (mem_finish),
        .refill_data (refill_data)
    );

    axi_refill_port port (
        .clk         (clk),
        .rst         (rst),
        .mem_start   (mem_start),
        .mem_job     (mem_job),
        .mem_finish  (mem_finish),
        .refill_data (refill_data),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata_m     (rdata_m),
        .rvalid      (rvalid),
        .rready      (rready),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .awready     (awready),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready)
    );

endmodule

`default_nettype wire

// ==== sim/axi_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_slave_model import dcache_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire addr_t araddr,
    input  wire logic  arvalid,
    output logic       arready,
    output data_t      rdata_m,
    output logic       rvalid,
    input  wire logic  rready,
    input  wire addr_t awaddr,
    input  wire logic  awvalid,
    output logic       awready,
    input  wire data_t wdata,
    input  wire logic  wvalid,
    output logic       wready,
    output logic       bvalid,
    input  wire logic  bready
);
    data_t       mem [256];
    logic        written [256]; // indexed by addr[9:2]
    logic [15:0] lfsr;
    logic [15:0] lfsr_next;
    logic [4:0]  rnd;
    logic        rd_pend;
    addr_t       rd_addr;
    logic        aw_got;
    logic        w_got;
    addr_t       wr_addr;
    data_t       wr_data;

    // contents of a word that was never written
    function automatic data_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1) ^ 32'h5a0f_c3a5;
    endfunction

    function automatic logic [15:0] advance(logic [15:0] s, int n);
        logic [15:0] r;
        r = s;
        for (int k = 0; k < n; k++) begin
            r = {r[14:0], r[15] ^ r[13] ^ r[12] ^ r[10]};
        end
        return r;
    endfunction

    assign lfsr_next = advance(lfsr, 5);
    assign rnd       = lfsr_next[4:0]; // five fresh bits each cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr    <= 16'd63;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            rd_pend <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            for (int i = 0; i < 256; i++) written[i] <= 1'b0;
        end else begin
            lfsr    <= lfsr_next;
            arready <= rnd[0] && !rd_pend && !rvalid && !(arvalid && arready);
            awready <= rnd[2] && !aw_got && !(awvalid && awready);
            wready  <= rnd[3] && !w_got && !(wvalid && wready);

            if (arvalid && arready) begin
                rd_pend <= 1'b1;
                rd_addr <= araddr;
            end
            // random latency before the read beat
            if (rd_pend && !rvalid && rnd[1]) begin
                rvalid  <= 1'b1;
                rd_pend <= 1'b0;
                rdata_m <= written[rd_addr[9:2]] ? mem[rd_addr[9:2]] : fill_word(rd_addr);
            end
            if (rvalid && rready) rvalid <= 1'b0;

            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                wr_addr <= awaddr;
            end
            if (wvalid && wready) begin
                w_got   <= 1'b1;
                wr_data <= wdata;
            end
            if (aw_got && w_got && !bvalid && rnd[4]) begin
                bvalid                <= 1'b1;
                aw_got                <= 1'b0;
                w_got                 <= 1'b0;
                mem[wr_addr[9:2]]     <= wr_data;
                written[wr_addr[9:2]] <= 1'b1;
            end
            if (bvalid && bready) bvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*; ();
    localparam int NUM_REQ      = 400;
    localparam int DONE_TIMEOUT = 200;

    logic     clk;
    logic     rst;
    logic     req;
    cpu_req_t creq;
    data_t    rdata;
    logic     done;
    addr_t    araddr;
    logic     arvalid;
    logic     arready;
    data_t    rdata_m;
    logic     rvalid;
    logic     rready;
    addr_t    awaddr;
    logic     awvalid;
    logic     awready;
    data_t    wdata;
    logic     wvalid;
    logic     wready;
    logic     bvalid;
    logic     bready;

    logic [15:0] lfsr;
    logic [26:0] tag_hi [4];    // low two bits pick the memory row
    int          value_errors;
    int          other_errors;
    logic        timed_out;

    // reference model of the cache and main memory
    logic [1:0] m_valid [8];
    logic [1:0] m_dirty [8];
    logic       m_lru [8];
    line_addr_t m_tag [8][2];
    data_t      m_data [8][2];
    data_t      m_mem [32];     // index is line[4:0]

    // bus monitor results for the current request
    int    ar_count;
    int    aw_count;
    int    w_count;
    logic  valid_seen;
    addr_t ar_addr_seen;
    addr_t aw_addr_seen;
    data_t w_data_seen;

    dcache_top #(
        .INDEX_W (3)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .creq    (creq),
        .rdata   (rdata),
        .done    (done),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata_m (rdata_m),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    axi_slave_model mem_model (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata_m (rdata_m),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (arvalid || awvalid || wvalid) valid_seen = 1'b1;
        if (arvalid && arready) begin
            ar_count++;
            ar_addr_seen = araddr;
        end
        if (awvalid && awready) begin
            aw_count++;
            aw_addr_seen = awaddr;
        end
        if (wvalid && wready) begin
            w_count++;
            w_data_seen = wdata;
        end
    end

    function automatic data_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b1) ^ 32'h5a0f_c3a5;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // store lanes replace the old word lanes
    function automatic data_t put_bytes(data_t old, byte_en_t be, data_t wd);
        data_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old & ~mask) | (wd & mask);
    endfunction

    task automatic check_data(string name, data_t exp, data_t act);
        if (exp !== act) begin
            $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_addr(string name, addr_t exp, addr_t act);
        if (exp !== act) begin
            $display("Fail %0t %s expected %h actual %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("Fail %0t %s expected %b actual %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic expect_transfers(string what, int expected, int seen);
        if (expected != seen) begin
            $display("at %0t expected %0d %s transfers but saw %0d", $time, expected, what, seen);
            other_errors++;
        end
    endtask

    task automatic run_request();
        cpu_req_t   r;
        line_addr_t line;
        logic [1:0] sel;
        logic [2:0] set;
        logic       store;
        logic       hit;
        logic       way;
        logic       wb;
        addr_t      wb_addr;
        data_t      wb_data;
        data_t      exp_word;
        int         cycles;

        sel     = 2'(rand_bits(2));
        set     = 3'(rand_bits(3));
        store   = 1'(rand_bits(1));
        r.addr  = {tag_hi[sel], set, 2'b00};
        r.wen   = store ? 4'(rand_bits(4)) : 4'h0;
        r.wdata = rand_bits(32);
        line    = r.addr[31:2];
        store   = |r.wen; // no lanes means load

        hit = 1'b0;
        way = m_lru[set];
        for (int w = 0; w < 2; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == line) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end
        wb      = !hit && m_valid[set][way] && m_dirty[set][way];
        wb_addr = {m_tag[set][way], 2'b00};
        wb_data = m_data[set][way];
        exp_word = put_bytes(hit ? m_data[set][way] : m_mem[line[4:0]], r.wen, r.wdata);

        @(negedge clk);
        req        = 1'b1;
        creq       = r;
        ar_count   = 0;
        aw_count   = 0;
        w_count    = 0;
        valid_seen = 1'b0;
        cycles     = 1; // the cycle that presents the request

        @(negedge clk);
        cycles = 2;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: request to %h got no done within %0d cycles", r.addr, cycles);
            other_errors++;
            timed_out = 1'b1;
        end else begin
            check_data("rdata", exp_word, rdata);
            if (hit) begin
                if (cycles != 2) begin
                    $display("hit to %h took %0d cycles instead of 2", r.addr, cycles);
                    other_errors++;
                end
                // lookup cycle itself is not sampled by the monitor yet
                check_bit("arvalid or awvalid on hit", 1'b0,
                          valid_seen || arvalid || awvalid || wvalid);
            end
            expect_transfers("read address", hit ? 0 : 1, ar_count);
            if (!hit && ar_count == 1) check_addr("araddr", {line, 2'b00}, ar_addr_seen);
            expect_transfers("write address", wb ? 1 : 0, aw_count);
            expect_transfers("write data", wb ? 1 : 0, w_count);
            if (wb && aw_count == 1) check_addr("awaddr", wb_addr, aw_addr_seen);
            if (wb && w_count == 1) check_data("wdata", wb_data, w_data_seen);
        end

        // advance the model
        if (wb) m_mem[wb_addr[6:2]] = wb_data;
        m_data[set][way] = exp_word;
        if (!hit) begin
            m_tag[set][way]   = line;
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = store;
        end else if (store) begin
            m_dirty[set][way] = 1'b1;
        end
        m_lru[set] = ~way;
    endtask

    initial begin
        lfsr         = 16'd63;
        rst          = 1'b1;
        req          = 1'b0;
        creq         = '0;
        value_errors = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        ar_count     = 0;
        aw_count     = 0;
        w_count      = 0;
        valid_seen   = 1'b0;
        tag_hi[0]    = 27'h000_0000;
        tag_hi[1]    = 27'h000_0001;
        tag_hi[2]    = 27'h555_5542;
        tag_hi[3]    = 27'h7ff_ffe3;
        for (int s = 0; s < 8; s++) begin
            m_valid[s] = 2'b00;
            m_dirty[s] = 2'b00;
            m_lru[s]   = 1'b0;
        end
        for (int i = 0; i < 32; i++) m_mem[i] = fill_word({tag_hi[i >> 3], 3'(i), 2'b00});

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_bit("done", 1'b0, done);
        check_bit("arvalid", 1'b0, arvalid);
        check_bit("rready", 1'b0, rready);
        check_bit("awvalid", 1'b0, awvalid);
        check_bit("wvalid", 1'b0, wvalid);
        check_bit("bready", 1'b0, bready);

        for (int n = 0; n < NUM_REQ && !timed_out; n++) run_request();

        $display("errors: %0d wrong values, %0d protocol or timeout", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/dcache_pkg.sv
hw/cache_ram.sv
hw/dcache_core.sv
hw/axi_refill_port.sv
hw/dcache_top.sv
sim/axi_slave_model.sv
sim/tb_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the dcache testbench with Verilator, run it, and grep the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
    && verilator --binary --timing -f project.f --top-module tb_dcache \
        -Mdir obj_dir -o tb_dcache \
    && ./obj_dir/tb_dcache | tee sim.log \
    && grep -q "^TEST PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
